// ==== Bender.yml ====
package:
  name: wasm_core

sources:
  - include_dirs:
      - .
    files:
      - wasm_pkg.sv
      - stack_if.sv
      - program_rom.sv
      - leb128_decoder.sv
      - value_stack.sv
      - program_counter.sv
      - exec_fsm.sv
      - wasm_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - wasm_core_chk.sv
      - wasm_core_tb.sv

// ==== exec_fsm.sv ====
`timescale 1ns/1ps
`include "wasm_params.svh"

module exec_fsm (
  input logic clk,
  input logic reset,
  input wasm_pkg::byte_t [`WASM_WINDOW:0] window,
  input logic range_error,
  input wasm_pkg::value_t leb_value,
  input wasm_pkg::leb_len_t leb_length,
  output logic pc_step,
  output logic pc_advance,
  output wasm_pkg::leb_len_t pc_length,
  stack_if.ctrl stk,
  output wasm_pkg::value_t result,
  output wasm_pkg::vtype_t result_type,
  output logic result_empty,
  output logic result_valid,
  output logic halted,
  output wasm_pkg::trap_t trap
);
  import wasm_pkg::*;

  exec_state_t state;
  byte_t opcode;
  byte_t op_q;
  stack_word_t aux_top;
  stack_word_t aux_second;
  logic running;
  logic stack_ok;
  logic cmp_eq;
  logic cmp_true;
  value_t f32_bits;
  value_t f64_bits;

  assign opcode = window[0];
  assign running = (trap == TRAP_NONE);
  assign halted = (state == S_HALTED);
  assign stack_ok = (stk.status == ST_READY) || (stk.status == ST_FULL);

  // Float immediates are little-endian raw bits
  assign f32_bits = {32'b0, window[4], window[3], window[2], window[1]};
  assign f64_bits = {window[8], window[7], window[6], window[5],
                     window[4], window[3], window[2], window[1]};

  // Saved top against the operand now on top
  always_comb begin
    case (op_q)
      `OP_I32_EQ, `OP_I32_NE: cmp_eq = (aux_top[31:0] == stk.tos[31:0]);
      default: cmp_eq = (aux_top[63:0] == stk.tos[63:0]);
    endcase
  end

  assign cmp_true = (op_q == `OP_I32_NE || op_q == `OP_I64_NE) ? !cmp_eq : cmp_eq;

  // Stack commands and counter moves for the current cycle
  always_comb begin
    stk.op = STK_NONE;
    stk.data = '0;
    pc_step = 1'b0;
    pc_advance = 1'b0;
    pc_length = leb_length;
    if (running) begin
      case (state)
        S_WAIT_STACK: pc_step = 1'b1;
        S_EXEC: begin
          if (!range_error) begin
            case (opcode)
              `OP_DROP: stk.op = STK_POP;
              `OP_I32_CONST, `OP_I64_CONST: begin
                stk.op = STK_PUSH;
                stk.data = {(opcode == `OP_I32_CONST) ? VT_I32 : VT_I64, leb_value};
                pc_advance = 1'b1;
              end
              `OP_F32_CONST: begin
                stk.op = STK_PUSH;
                stk.data = {VT_F32, f32_bits};
                pc_advance = 1'b1;
                pc_length = 4'd4;
              end
              `OP_F64_CONST: begin
                stk.op = STK_PUSH;
                stk.data = {VT_F64, f64_bits};
                pc_advance = 1'b1;
                pc_length = 4'd8;
              end
              `OP_I32_EQZ: begin
                stk.op = STK_REPLACE;
                stk.data = {VT_I32, 63'b0, stk.tos[31:0] == 32'b0};
              end
              `OP_I64_EQZ: begin
                stk.op = STK_REPLACE;
                stk.data = {VT_I32, 63'b0, stk.tos[63:0] == 64'b0};
              end
              `OP_I32_REINTERPRET_F32: begin
                stk.op = STK_REPLACE;
                stk.data = {VT_I32, stk.tos[63:0]};
              end
              `OP_SELECT, `OP_I32_EQ, `OP_I32_NE, `OP_I64_EQ, `OP_I64_NE:
                stk.op = STK_POP;
              default: ;
            endcase
          end
        end
        // Second operand of select leaves the stack
        S_EXEC2: if (op_q == `OP_SELECT) stk.op = STK_POP;
        S_EXEC3: begin
          if (op_q != `OP_SELECT && stack_ok) begin
            stk.op = STK_REPLACE;
            stk.data = {VT_I32, 63'b0, cmp_true};
          end
        end
        // Zero condition picks the second operand
        S_EXEC4: begin
          if (aux_top[31:0] == 32'b0) begin
            stk.op = STK_REPLACE;
            stk.data = aux_second;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_FETCH;
      trap <= TRAP_NONE;
      result_valid <= 1'b0;
    end else begin
      result_valid <= 1'b0;
      // A latched trap freezes everything
      if (running) begin
        case (state)
          S_FETCH: state <= S_WAIT_STACK;
          S_WAIT_STACK: begin
            if (stk.status == ST_FAULT) trap <= TRAP_STACK;
            else state <= S_EXEC;
          end
          S_EXEC: begin
            op_q <= opcode;
            state <= S_FETCH;
            if (range_error) begin
              trap <= TRAP_RANGE;
            end else begin
              case (opcode)
                `OP_UNREACHABLE: trap <= TRAP_UNREACHABLE;
                `OP_NOP, `OP_DROP, `OP_I32_CONST, `OP_I64_CONST, `OP_F32_CONST,
                `OP_F64_CONST, `OP_I32_EQZ, `OP_I64_EQZ, `OP_I32_REINTERPRET_F32: ;
                `OP_END: begin
                  result <= stk.tos[63:0];
                  result_type <= stk.tos[65:64];
                  result_empty <= (stk.status == ST_EMPTY);
                  result_valid <= 1'b1;
                  state <= S_HALTED;
                end
                `OP_SELECT, `OP_I32_EQ, `OP_I32_NE, `OP_I64_EQ, `OP_I64_NE: begin
                  aux_top <= stk.tos;
                  state <= S_EXEC2;
                end
                default: trap <= TRAP_UNKNOWN;
              endcase
            end
          end
          S_EXEC2: begin
            if (op_q == `OP_SELECT) aux_second <= stk.tos;
            state <= S_EXEC3;
          end
          S_EXEC3: begin
            state <= S_FETCH;
            // Too few operands leave the stack empty or faulted
            if (!stack_ok) trap <= TRAP_STACK;
            else if (op_q == `OP_SELECT) begin
              if (aux_second[65:64] != stk.tos[65:64]) trap <= TRAP_SELECT;
              else state <= S_EXEC4;
            end
          end
          S_EXEC4: state <= S_FETCH;
          default: ;
        endcase
      end
    end
  end

endmodule

// ==== filelist.f ====
+incdir+.
wasm_pkg.sv
stack_if.sv
program_rom.sv
leb128_decoder.sv
value_stack.sv
program_counter.sv
exec_fsm.sv
wasm_core.sv
wasm_core_chk.sv
wasm_core_tb.sv

// ==== leb128_decoder.sv ====
`timescale 1ns/1ps
`include "wasm_params.svh"

module leb128_decoder (
  input wasm_pkg::byte_t [`WASM_WINDOW-1:0] bytes,
  output wasm_pkg::value_t value,
  output wasm_pkg::leb_len_t length
);
  import wasm_pkg::*;

  // Ten groups of seven bits cover 70 bits, the top six are dropped
  logic [7*`WASM_WINDOW-1:0] acc;
  leb_len_t last;
  logic sign;

  // Index of the first byte without a continuation bit
  always_comb begin
    logic found;
    found = 1'b0;
    last = leb_len_t'(`WASM_WINDOW - 1);
    for (int i = 0; i < `WASM_WINDOW; i++) begin
      if (!found && !bytes[i][7]) begin
        found = 1'b1;
        last = leb_len_t'(i);
      end
    end
  end

  // Sign of the final group
  assign sign = bytes[last][6];

  // Payload groups up to the last byte, sign fill above
  always_comb begin
    acc = '0;
    for (int i = 0; i < `WASM_WINDOW; i++) begin
      if (leb_len_t'(i) <= last) begin
        acc[7*i +: 7] = bytes[i][6:0];
      end else begin
        acc[7*i +: 7] = {7{sign}};
      end
    end
  end

  assign value = acc[63:0];
  assign length = last + 4'd1;

endmodule

// ==== program_counter.sv ====
`timescale 1ns/1ps

module program_counter (
  input logic clk,
  input logic reset,
  input logic step,
  input logic advance,
  input wasm_pkg::leb_len_t length,
  output wasm_pkg::code_addr_t pc
);
  import wasm_pkg::*;

  code_addr_t pc_next;

  // Skipping an immediate wins over a single step
  always_comb begin
    if (advance) begin
      pc_next = pc + code_addr_t'(length);
    end else if (step) begin
      pc_next = pc + 1'b1;
    end else begin
      pc_next = pc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

// ==== program_rom.sv ====
`timescale 1ns/1ps
`include "wasm_params.svh"

module program_rom (
  input logic clk,
  input logic load_en,
  input wasm_pkg::code_addr_t load_addr,
  input wasm_pkg::byte_t load_data,
  input wasm_pkg::code_addr_t rd_addr,
  output wasm_pkg::byte_t [`WASM_WINDOW:0] window,
  output logic range_error
);
  import wasm_pkg::*;

  byte_t mem [`WASM_ROM_SIZE];
  byte_t [`WASM_WINDOW:0] win_next;

  // Byte loader, only used while the core sits in reset
  always_ff @(posedge clk) begin
    if (load_en && load_addr < `WASM_ROM_SIZE) begin
      mem[load_addr[`WASM_ROM_ADDR-1:0]] <= load_data;
    end
  end

  // Opcode plus immediate bytes, zero past the end
  always_comb begin
    logic [`WASM_ROM_ADDR+1:0] addr;
    addr = '0;
    for (int i = 0; i <= `WASM_WINDOW; i++) begin
      addr = {1'b0, rd_addr} + (`WASM_ROM_ADDR+2)'(i);
      if (addr < `WASM_ROM_SIZE) begin
        win_next[i] = mem[addr[`WASM_ROM_ADDR-1:0]];
      end else begin
        win_next[i] = '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    window <= win_next;
    range_error <= (rd_addr >= `WASM_ROM_SIZE);
  end

endmodule

// ==== stack_if.sv ====
`timescale 1ns/1ps

interface stack_if;
  import wasm_pkg::*;

  // Command for the next clock edge
  stack_op_t op;
  stack_word_t data;

  // Current top entry and fill state
  stack_word_t tos;
  stack_status_t status;

  modport ctrl (
    output op,
    output data,
    input tos,
    input status
  );

  modport mem (
    input op,
    input data,
    output tos,
    output status
  );

endinterface

// ==== value_stack.sv ====
`timescale 1ns/1ps
`include "wasm_params.svh"

module value_stack #(
  parameter int DEPTH = `WASM_STACK_DEPTH
) (
  input logic clk,
  input logic reset,
  stack_if.mem stk
);
  import wasm_pkg::*;

  localparam int CW = $clog2(DEPTH + 1);
  localparam int AW = $clog2(DEPTH);

  stack_word_t entries [DEPTH];
  logic [CW-1:0] count;
  logic fault;
  logic is_empty;
  logic is_full;
  logic [AW-1:0] top_idx;
  logic [AW-1:0] push_idx;

  assign is_empty = (count == '0);
  assign is_full = (count == CW'(DEPTH));
  assign top_idx = AW'(count - 1'b1);
  assign push_idx = AW'(count);

  // Fill count and sticky fault flag
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      fault <= 1'b0;
    end else begin
      case (stk.op)
        STK_PUSH: begin
          if (is_full) fault <= 1'b1;
          else count <= count + 1'b1;
        end
        STK_POP: begin
          if (is_empty) fault <= 1'b1;
          else count <= count - 1'b1;
        end
        STK_REPLACE: begin
          if (is_empty) fault <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (stk.op == STK_PUSH && !is_full) begin
      entries[push_idx] <= stk.data;
    end else if (stk.op == STK_REPLACE && !is_empty) begin
      entries[top_idx] <= stk.data;
    end
  end

  assign stk.tos = is_empty ? '0 : entries[top_idx];

  always_comb begin
    if (fault) stk.status = ST_FAULT;
    else if (is_empty) stk.status = ST_EMPTY;
    else if (is_full) stk.status = ST_FULL;
    else stk.status = ST_READY;
  end

endmodule

// ==== wasm_core.sv ====
`timescale 1ns/1ps
`include "wasm_params.svh"

module wasm_core (
  input logic clk,
  input logic reset,
  input logic load_en,
  input wasm_pkg::code_addr_t load_addr,
  input wasm_pkg::byte_t load_data,
  output wasm_pkg::value_t result,
  output wasm_pkg::vtype_t result_type,
  output logic result_empty,
  output logic result_valid,
  output logic halted,
  output wasm_pkg::trap_t trap
);
  import wasm_pkg::*;

  byte_t [`WASM_WINDOW:0] window;
  logic range_error;
  value_t leb_value;
  leb_len_t leb_length;
  logic pc_step;
  logic pc_advance;
  leb_len_t pc_length;
  code_addr_t pc;

  stack_if stk ();

  // Read window always follows the counter
  program_rom i_program_rom (
    .clk(clk),
    .load_en(load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .rd_addr(pc),
    .window(window),
    .range_error(range_error)
  );

  // Immediates start right after the opcode byte
  leb128_decoder i_leb128_decoder (
    .bytes(window[`WASM_WINDOW:1]),
    .value(leb_value),
    .length(leb_length)
  );

  value_stack #(
    .DEPTH(`WASM_STACK_DEPTH)
  ) i_value_stack (
    .clk(clk),
    .reset(reset),
    .stk(stk.mem)
  );

  program_counter i_program_counter (
    .clk(clk),
    .reset(reset),
    .step(pc_step),
    .advance(pc_advance),
    .length(pc_length),
    .pc(pc)
  );

  exec_fsm i_exec_fsm (
    .clk(clk),
    .reset(reset),
    .window(window),
    .range_error(range_error),
    .leb_value(leb_value),
    .leb_length(leb_length),
    .pc_step(pc_step),
    .pc_advance(pc_advance),
    .pc_length(pc_length),
    .stk(stk.ctrl),
    .result(result),
    .result_type(result_type),
    .result_empty(result_empty),
    .result_valid(result_valid),
    .halted(halted),
    .trap(trap)
  );

endmodule

// ==== wasm_core_chk.sv ====
`timescale 1ns/1ps

module wasm_core_chk (
  input logic clk,
  input logic reset,
  input logic result_valid,
  input logic halted,
  input wasm_pkg::trap_t trap
);

  // Failure counts per property
  int trap_fails = 0;
  int strobe_fails = 0;
  int overlap_fails = 0;

  // A trap code stays latched until reset
  trap_hold: assert property (
    @(posedge clk) disable iff (reset)
    (trap != 3'd0) |=> (trap == $past(trap))
  ) else begin
    $error("trap code changed while out of reset");
    trap_fails++;
  end

  // End strobe is one cycle wide, core halted with it and after it
  strobe_one_cycle: assert property (
    @(posedge clk) disable iff (reset)
    result_valid |-> halted ##1 (halted && !result_valid)
  ) else begin
    $error("result_valid not a single cycle strobe into halted");
    strobe_fails++;
  end

  no_result_on_trap: assert property (
    @(posedge clk) disable iff (reset)
    !(result_valid && trap != 3'd0)
  ) else begin
    $error("result_valid high together with a trap");
    overlap_fails++;
  end

endmodule

// ==== wasm_core_tb.sv ====
`timescale 1ns/1ps
`include "wasm_params.svh"

module wasm_core_tb;
  import wasm_pkg::*;

  localparam int NUM_PROGRAMS = 40;
  localparam int ROM_BYTES = 64;
  localparam int TIMEOUT_CYCLES = NUM_PROGRAMS * (64 + 5 + 64 * 6) + 2000;

  logic clk;
  logic reset;
  logic load_en;
  code_addr_t load_addr;
  byte_t load_data;
  value_t result;
  vtype_t result_type;
  logic result_empty;
  logic result_valid;
  logic halted;
  trap_t trap;

  logic [31:0] rng_state;
  byte_t prog [ROM_BYTES];
  int plen;
  int prog_index;
  int check_count;
  int error_count;
  int assert_fails;
  int cycle_count;

  // Predicted outcome of the current program
  trap_t exp_trap;
  value_t exp_result;
  vtype_t exp_type;
  logic exp_empty;

  wasm_core i_wasm_core (
    .clk(clk),
    .reset(reset),
    .load_en(load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .result(result),
    .result_type(result_type),
    .result_empty(result_empty),
    .result_valid(result_valid),
    .halted(halted),
    .trap(trap)
  );

  bind wasm_core wasm_core_chk i_wasm_core_chk (
    .clk(clk),
    .reset(reset),
    .result_valid(result_valid),
    .halted(halted),
    .trap(trap)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Run limit over all programs
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: no result or trap after %0d cycles", cycle_count);
      $display("tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic emit(input byte_t b);
    prog[plen] = b;
    plen = plen + 1;
  endtask

  task automatic emit_copy(input int start, input int len);
    for (int i = 0; i < len; i++) begin
      emit(prog[start + i]);
    end
  endtask

  // Opcode and a LEB128 immediate of 1 to max_len bytes
  task automatic emit_leb_const(input byte_t op, input int max_len);
    int n;
    logic [31:0] r;
    byte_t b;
    n = 1 + int'(xorshift32() % max_len);
    emit(op);
    for (int i = 0; i < n; i++) begin
      r = xorshift32();
      b = r[7:0];
      b[7] = (i != n - 1);
      emit(b);
    end
  endtask

  task automatic emit_const_of_type(input vtype_t t, input int max_len);
    logic [31:0] r;
    int n;
    case (t)
      VT_I32: emit_leb_const(`OP_I32_CONST, max_len);
      VT_I64: emit_leb_const(`OP_I64_CONST, max_len);
      default: begin
        n = (t == VT_F32) ? 4 : 8;
        emit((t == VT_F32) ? `OP_F32_CONST : `OP_F64_CONST);
        for (int i = 0; i < n; i++) begin
          r = xorshift32();
          emit(r[7:0]);
        end
      end
    endcase
  endtask

  task automatic build_program(input int kind);
    int start;
    int sel;
    vtype_t t;
    logic [31:0] r;
    plen = 0;
    sel = int'(xorshift32() % 6);
    case (kind)
      0: begin
        repeat (1 + sel % 4) emit_const_of_type(vtype_t'(xorshift32() % 4), 10);
        emit(`OP_END);
      end
      1: begin
        t = (sel < 3) ? VT_I32 : VT_I64;
        if (sel % 3 == 0) begin
          // Zero operand half of the time
          if (xorshift32() % 2 == 0) begin
            emit((t == VT_I32) ? `OP_I32_CONST : `OP_I64_CONST);
            emit(8'h00);
          end else begin
            emit_const_of_type(t, 10);
          end
          emit((t == VT_I32) ? `OP_I32_EQZ : `OP_I64_EQZ);
        end else begin
          start = plen;
          emit_const_of_type(t, 10);
          if (xorshift32() % 2 == 0) emit_copy(start, plen - start);
          else emit_const_of_type(t, 10);
          case (sel)
            1: emit(`OP_I32_EQ);
            2: emit(`OP_I32_NE);
            4: emit(`OP_I64_EQ);
            default: emit(`OP_I64_NE);
          endcase
        end
        emit(`OP_END);
      end
      2: begin
        t = vtype_t'(xorshift32() % 4);
        emit_const_of_type(t, 10);
        // Second operand of any type so that types differ now and then
        if (sel < 2) emit_const_of_type(vtype_t'(xorshift32() % 4), 10);
        else emit_const_of_type(t, 10);
        if (xorshift32() % 2 == 0) begin
          emit(`OP_I32_CONST);
          emit(8'h00);
        end else begin
          emit_leb_const(`OP_I32_CONST, 5);
        end
        emit(`OP_SELECT);
        emit(`OP_END);
      end
      3: begin
        if (sel < 2) begin
          emit(`OP_DROP);
        end else if (sel < 4) begin
          repeat (9) emit_leb_const(`OP_I32_CONST, 1);
        end
        emit(`OP_END);
      end
      4: begin
        emit_const_of_type(vtype_t'(xorshift32() % 4), 3);
        r = xorshift32();
        if (sel < 2) emit(`OP_UNREACHABLE);
        else if (sel < 4) emit(8'hc0 | r[7:0]);
        // Remaining programs have no end and run into the nop fill
        if (sel < 4) emit(`OP_END);
      end
      default: begin
        repeat (2 + sel % 5) begin
          case (xorshift32() % 5)
            0, 1: emit_const_of_type(vtype_t'(xorshift32() % 4), 4);
            2: emit(`OP_DROP);
            3: emit(`OP_NOP);
            default: emit(`OP_I32_REINTERPRET_F32);
          endcase
        end
        emit(`OP_END);
      end
    endcase
    for (int i = plen; i < ROM_BYTES; i++) begin
      prog[i] = `OP_NOP;
    end
  endtask

  function automatic byte_t rom_byte(input int addr);
    if (addr < ROM_BYTES) return prog[addr];
    return 8'h00;
  endfunction

  // Signed LEB128 with the sign from bit 6 of the last group
  task automatic decode_leb(input int at, output value_t val, output int len);
    byte_t b;
    val = '0;
    len = 0;
    b = 8'h80;
    while (b[7] && len < 10) begin
      b = rom_byte(at + len);
      val = val | (value_t'(b[6:0]) << (7 * len));
      len = len + 1;
    end
    if (7 * len < 64 && b[6]) val = val | ({64{1'b1}} << (7 * len));
  endtask

  task automatic run_model();
    stack_word_t stk [$];
    stack_word_t a;
    stack_word_t c;
    value_t v;
    int pc;
    int n;
    int top;
    byte_t op;
    logic done;
    logic push_req;
    logic eq;
    exp_trap = TRAP_NONE;
    exp_result = '0;
    exp_type = VT_I32;
    exp_empty = 1'b0;
    pc = 0;
    done = 1'b0;
    while (!done && exp_trap == TRAP_NONE) begin
      push_req = 1'b0;
      top = stk.size() - 1;
      if (pc >= ROM_BYTES) begin
        exp_trap = TRAP_RANGE;
      end else begin
        op = prog[pc];
        pc = pc + 1;
        case (op)
          `OP_UNREACHABLE: exp_trap = TRAP_UNREACHABLE;
          `OP_NOP: ;
          `OP_END: begin
            done = 1'b1;
            exp_empty = (stk.size() == 0);
            if (!exp_empty) {exp_type, exp_result} = stk[top];
          end
          `OP_DROP: begin
            if (stk.size() == 0) exp_trap = TRAP_STACK;
            else void'(stk.pop_back());
          end
          `OP_I32_CONST, `OP_I64_CONST: begin
            decode_leb(pc, v, n);
            pc = pc + n;
            a = {(op == `OP_I32_CONST) ? VT_I32 : VT_I64, v};
            push_req = 1'b1;
          end
          `OP_F32_CONST, `OP_F64_CONST: begin
            // Raw little-endian bits
            n = (op == `OP_F32_CONST) ? 4 : 8;
            v = '0;
            for (int i = 0; i < n; i++) begin
              v[8*i +: 8] = rom_byte(pc + i);
            end
            pc = pc + n;
            a = {(op == `OP_F32_CONST) ? VT_F32 : VT_F64, v};
            push_req = 1'b1;
          end
          `OP_I32_EQZ, `OP_I64_EQZ: begin
            if (stk.size() == 0) begin
              exp_trap = TRAP_STACK;
            end else begin
              a = stk[top];
              if (op == `OP_I32_EQZ) eq = (a[31:0] == 32'b0);
              else eq = (a[63:0] == 64'b0);
              stk[top] = {VT_I32, 63'b0, eq};
            end
          end
          `OP_I32_EQ, `OP_I32_NE, `OP_I64_EQ, `OP_I64_NE: begin
            if (stk.size() < 2) begin
              exp_trap = TRAP_STACK;
            end else begin
              a = stk.pop_back();
              c = stk[top - 1];
              if (op == `OP_I32_EQ || op == `OP_I32_NE) eq = (a[31:0] == c[31:0]);
              else eq = (a[63:0] == c[63:0]);
              if (op == `OP_I32_NE || op == `OP_I64_NE) eq = !eq;
              stk[top - 1] = {VT_I32, 63'b0, eq};
            end
          end
          `OP_SELECT: begin
            if (stk.size() < 3) begin
              exp_trap = TRAP_STACK;
            end else begin
              c = stk.pop_back();
              a = stk.pop_back();
              // First operand stays below the popped pair
              if (a[65:64] != stk[top - 2][65:64]) exp_trap = TRAP_SELECT;
              else if (c[31:0] == 32'b0) stk[top - 2] = a;
            end
          end
          `OP_I32_REINTERPRET_F32: begin
            if (stk.size() == 0) begin
              exp_trap = TRAP_STACK;
            end else begin
              a = stk[top];
              stk[top] = {VT_I32, a[63:0]};
            end
          end
          default: exp_trap = TRAP_UNKNOWN;
        endcase
      end
      if (push_req) begin
        if (stk.size() == `WASM_STACK_DEPTH) exp_trap = TRAP_STACK;
        else stk.push_back(a);
      end
    end
  endtask

  // Byte strobes while the core is held in reset
  task automatic load_program();
    // Cycle after the last strobe or trap runs out of reset
    repeat (2) next_cycle();
    reset = 1'b1;
    for (int i = 0; i < ROM_BYTES; i++) begin
      load_en = 1'b1;
      load_addr = code_addr_t'(i);
      load_data = prog[i];
      next_cycle();
    end
    load_en = 1'b0;
    repeat (5) next_cycle();
    reset = 1'b0;
  endtask

  task automatic wait_done();
    @(negedge clk);
    while (!result_valid && trap == TRAP_NONE) @(negedge clk);
  endtask

  task automatic check_value(input string what, input value_t got, input value_t exp);
    check_count = check_count + 1;
    if (got !== exp) begin
      error_count = error_count + 1;
      $display("[FAIL] %0t ns: program %0d %s is %h, expected %h",
               $time, prog_index, what, got, exp);
    end
  endtask

  task automatic check_outcome();
    check_value("trap", value_t'(trap), value_t'(exp_trap));
    if (exp_trap == TRAP_NONE) begin
      check_value("halted", value_t'(halted), value_t'(1'b1));
      check_value("result_empty", value_t'(result_empty), value_t'(exp_empty));
      if (!exp_empty) begin
        check_value("result", result, exp_result);
        check_value("result_type", value_t'(result_type), value_t'(exp_type));
      end
    end
  endtask

  initial begin
    rng_state = 32'h86bb_09fa;
    reset = 1'b1;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    plen = 0;
    check_count = 0;
    error_count = 0;
    cycle_count = 0;
    repeat (5) @(posedge clk);
    for (prog_index = 0; prog_index < NUM_PROGRAMS; prog_index++) begin
      build_program(prog_index % 6);
      run_model();
      load_program();
      wait_done();
      check_outcome();
    end
    assert_fails = i_wasm_core.i_wasm_core_chk.trap_fails +
                   i_wasm_core.i_wasm_core_chk.strobe_fails +
                   i_wasm_core.i_wasm_core_chk.overlap_fails;
    $display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
             check_count, error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== wasm_params.svh ====
`ifndef WASM_PARAMS_SVH
`define WASM_PARAMS_SVH

// Program memory geometry
`define WASM_ROM_ADDR 6
`define WASM_ROM_SIZE (1 << `WASM_ROM_ADDR)

// Value stack entries
`define WASM_STACK_DEPTH 8

// Immediate bytes visible after the opcode
`define WASM_WINDOW 10

// Control and parametric opcodes
`define OP_UNREACHABLE 8'h00
`define OP_NOP 8'h01
`define OP_END 8'h0b
`define OP_DROP 8'h1a
`define OP_SELECT 8'h1b

// Constants
`define OP_I32_CONST 8'h41
`define OP_I64_CONST 8'h42
`define OP_F32_CONST 8'h43
`define OP_F64_CONST 8'h44

// Comparisons and reinterpretation
`define OP_I32_EQZ 8'h45
`define OP_I32_EQ 8'h46
`define OP_I32_NE 8'h47
`define OP_I64_EQZ 8'h50
`define OP_I64_EQ 8'h51
`define OP_I64_NE 8'h52
`define OP_I32_REINTERPRET_F32 8'hbc

`endif

// ==== wasm_pkg.sv ====
`include "wasm_params.svh"

package wasm_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [63:0] value_t;

  // Value type tag, stored above the payload
  typedef logic [1:0] vtype_t;

  localparam vtype_t VT_I32 = 2'd0;
  localparam vtype_t VT_I64 = 2'd1;
  localparam vtype_t VT_F32 = 2'd2;
  localparam vtype_t VT_F64 = 2'd3;

  // Bits 65:64 hold the type, 63:0 the payload
  typedef logic [65:0] stack_word_t;

  // One extra bit so running past the end is visible
  typedef logic [`WASM_ROM_ADDR:0] code_addr_t;

  typedef logic [2:0] trap_t;

  localparam trap_t TRAP_NONE = 3'd0;
  localparam trap_t TRAP_STACK = 3'd1;
  localparam trap_t TRAP_RANGE = 3'd2;
  localparam trap_t TRAP_UNREACHABLE = 3'd3;
  localparam trap_t TRAP_UNKNOWN = 3'd4;
  localparam trap_t TRAP_SELECT = 3'd5;

  // Byte count of a LEB128 immediate, 1 to 10
  typedef logic [3:0] leb_len_t;

  typedef enum logic [1:0] {
    STK_NONE,
    STK_PUSH,
    STK_POP,
    STK_REPLACE
  } stack_op_t;

  typedef enum logic [1:0] {
    ST_EMPTY,
    ST_READY,
    ST_FULL,
    ST_FAULT
  } stack_status_t;

  typedef enum logic [2:0] {
    S_FETCH,
    S_WAIT_STACK,
    S_EXEC,
    S_EXEC2,
    S_EXEC3,
    S_EXEC4,
    S_HALTED
  } exec_state_t;

endpackage
